/* source/lc4ss_pkg.sv */
package lc4ss_pkg;

  typedef logic [15:0] word_t;    // data, address or instruction word
  typedef logic [2:0]  reg_sel_t;
  typedef logic [4:0]  ctrl_t;

  // bit positions inside ctrl_t
  localparam int CTRL_RS_RE    = 4;
  localparam int CTRL_RT_RE    = 3;
  localparam int CTRL_RF_WE    = 2;
  localparam int CTRL_IS_LOAD  = 1;
  localparam int CTRL_IS_STORE = 0;

  // stall code carried down each lane to the trace
  typedef enum logic [1:0] {
    STALL_NONE        = 2'd0,
    STALL_SUPERSCALAR = 2'd1,  // partner lane or memory port
    STALL_RESET       = 2'd2,
    STALL_LOAD_USE    = 2'd3
  } stall_t;

  localparam word_t RESET_PC = 16'h8200;
  localparam int    NUM_REGS = 8;

  localparam logic [3:0] OP_NOP   = 4'h0;
  localparam logic [3:0] OP_ARITH = 4'h1;
  localparam logic [3:0] OP_LOGIC = 4'h5;
  localparam logic [3:0] OP_LDR   = 4'h6;
  localparam logic [3:0] OP_STR   = 4'h7;
  localparam logic [3:0] OP_CONST = 4'h9;

  // subopcodes in insn[5:3]
  localparam logic [2:0] SUB_ADD = 3'b000;
  localparam logic [2:0] SUB_SUB = 3'b010;
  localparam logic [2:0] SUB_AND = 3'b000;
  localparam logic [2:0] SUB_OR  = 3'b010;
  localparam logic [2:0] SUB_XOR = 3'b011;

endpackage

/* source/lc4ss_decoder.sv */
`timescale 1ns/1ps

module lc4ss_decoder import lc4ss_pkg::*; (
  input  word_t    i_insn,
  output ctrl_t    o_ctrl,
  output reg_sel_t o_rs,
  output reg_sel_t o_rt,
  output reg_sel_t o_rd
);

  logic [3:0] opcode;
  logic [2:0] subop;

  assign opcode = i_insn[15:12];
  assign subop  = i_insn[5:3];

  always_comb begin
    o_ctrl = '0;
    o_rs   = i_insn[8:6];
    o_rt   = i_insn[2:0];
    o_rd   = i_insn[11:9];
    case (opcode)
      OP_NOP: ;
      OP_ARITH: begin
        if (subop[2]) begin  // add immediate
          o_ctrl[CTRL_RS_RE] = 1'b1;
          o_ctrl[CTRL_RF_WE] = 1'b1;
        end else if (subop == SUB_ADD || subop == SUB_SUB) begin
          o_ctrl[CTRL_RS_RE] = 1'b1;
          o_ctrl[CTRL_RT_RE] = 1'b1;
          o_ctrl[CTRL_RF_WE] = 1'b1;
        end
      end
      OP_LOGIC: begin
        if (subop == SUB_AND || subop == SUB_OR || subop == SUB_XOR) begin
          o_ctrl[CTRL_RS_RE] = 1'b1;
          o_ctrl[CTRL_RT_RE] = 1'b1;
          o_ctrl[CTRL_RF_WE] = 1'b1;
        end
      end
      OP_LDR: begin
        o_ctrl[CTRL_RS_RE]   = 1'b1;
        o_ctrl[CTRL_RF_WE]   = 1'b1;
        o_ctrl[CTRL_IS_LOAD] = 1'b1;
      end
      OP_STR: begin
        o_rt                  = i_insn[11:9];  // store data comes from rt
        o_ctrl[CTRL_RS_RE]    = 1'b1;
        o_ctrl[CTRL_RT_RE]    = 1'b1;
        o_ctrl[CTRL_IS_STORE] = 1'b1;
      end
      OP_CONST: o_ctrl[CTRL_RF_WE] = 1'b1;
      default: o_ctrl = '0;  // anything else behaves as a nop
    endcase
  end

endmodule

/* source/lc4ss_alu.sv */
`timescale 1ns/1ps

module lc4ss_alu import lc4ss_pkg::*; (
  input  word_t i_insn,
  input  word_t i_rs_data,
  input  word_t i_rt_data,
  output word_t o_result
);

  word_t      imm5;
  word_t      imm6;
  word_t      imm9;
  logic [2:0] subop;

  assign imm5  = {{11{i_insn[4]}}, i_insn[4:0]};
  assign imm6  = {{10{i_insn[5]}}, i_insn[5:0]};  // load/store offset
  assign imm9  = {{7{i_insn[8]}}, i_insn[8:0]};
  assign subop = i_insn[5:3];

  always_comb begin
    case (i_insn[15:12])
      OP_ARITH: begin
        if (subop[2])
          o_result = i_rs_data + imm5;
        else if (subop == SUB_SUB)
          o_result = i_rs_data - i_rt_data;
        else
          o_result = i_rs_data + i_rt_data;
      end
      OP_LOGIC: begin
        case (subop)
          SUB_AND: o_result = i_rs_data & i_rt_data;
          SUB_OR:  o_result = i_rs_data | i_rt_data;
          SUB_XOR: o_result = i_rs_data ^ i_rt_data;
          default: o_result = '0;
        endcase
      end
      OP_LDR, OP_STR: o_result = i_rs_data + imm6;  // effective address
      OP_CONST:       o_result = imm9;
      default:        o_result = '0;
    endcase
  end

endmodule

/* source/lc4ss_regfile.sv */
`timescale 1ns/1ps

module lc4ss_regfile import lc4ss_pkg::*; (
  input  logic     gwe,
  input  logic     i_reset,
  input  reg_sel_t i_rs_a,
  input  reg_sel_t i_rt_a,
  input  reg_sel_t i_rs_b,
  input  reg_sel_t i_rt_b,
  output word_t    o_rs_data_a,
  output word_t    o_rt_data_a,
  output word_t    o_rs_data_b,
  output word_t    o_rt_data_b,
  input  logic     i_we_a,
  input  logic     i_we_b,
  input  reg_sel_t i_wsel_a,
  input  reg_sel_t i_wsel_b,
  input  word_t    i_wdata_a,
  input  word_t    i_wdata_b
);

  word_t regs [NUM_REGS];

  // same-cycle writes are visible, lane b is younger so it is checked first
  function automatic word_t read_port(reg_sel_t sel);
    if (i_we_b && i_wsel_b == sel)
      return i_wdata_b;
    if (i_we_a && i_wsel_a == sel)
      return i_wdata_a;
    return regs[sel];
  endfunction

  assign o_rs_data_a = read_port(i_rs_a);
  assign o_rt_data_a = read_port(i_rt_a);
  assign o_rs_data_b = read_port(i_rs_b);
  assign o_rt_data_b = read_port(i_rt_b);

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else begin
      if (i_we_a)
        regs[i_wsel_a] <= i_wdata_a;
      if (i_we_b)
        regs[i_wsel_b] <= i_wdata_b;  // last write wins on a collision
    end
  end

endmodule

/* source/lc4ss_fetch.sv */
`timescale 1ns/1ps

module lc4ss_fetch import lc4ss_pkg::*; (
  input  logic  gwe,
  input  logic  i_reset,
  input  logic  i_issue_a,
  input  logic  i_issue_b,
  input  word_t i_imem_insn_a,
  input  word_t i_imem_insn_b,
  output word_t o_imem_pc,
  output logic  o_d_valid_a,
  output logic  o_d_valid_b,
  output word_t o_d_insn_a,
  output word_t o_d_insn_b,
  output word_t o_d_pc_a,
  output word_t o_d_pc_b
);

  word_t pc;
  logic  valid;         // both slots fill together so one bit covers them
  logic  take_pair;
  logic  switch_pipes;

  assign take_pair    = !valid || i_issue_b;    // slots empty or both issued
  assign switch_pipes = i_issue_a && !i_issue_b;

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      pc    <= RESET_PC;
      valid <= 1'b0;
    end else if (take_pair) begin
      pc    <= pc + 16'd2;
      valid <= 1'b1;
    end else if (switch_pipes) begin
      pc <= pc + 16'd1;
    end
  end

  always_ff @(posedge gwe) begin
    if (take_pair) begin
      o_d_insn_a <= i_imem_insn_a;
      o_d_insn_b <= i_imem_insn_b;
      o_d_pc_a   <= pc;
      o_d_pc_b   <= pc + 16'd1;
    end else if (switch_pipes) begin
      // the waiting b insn becomes the older one
      o_d_insn_a <= o_d_insn_b;
      o_d_pc_a   <= o_d_pc_b;
      o_d_insn_b <= i_imem_insn_a;
      o_d_pc_b   <= pc;
    end
  end

  assign o_imem_pc   = pc;
  assign o_d_valid_a = valid;
  assign o_d_valid_b = valid;

endmodule

/* source/lc4ss_issue.sv */
`timescale 1ns/1ps

module lc4ss_issue import lc4ss_pkg::*; (
  input  logic     i_d_valid_a,
  input  logic     i_d_valid_b,
  input  ctrl_t    i_ctrl_a,
  input  ctrl_t    i_ctrl_b,
  input  reg_sel_t i_rs_a,
  input  reg_sel_t i_rt_a,
  input  reg_sel_t i_rd_a,
  input  reg_sel_t i_rs_b,
  input  reg_sel_t i_rt_b,
  input  reg_sel_t i_rd_b,
  input  logic     i_x_load_a,
  input  logic     i_x_load_b,
  input  reg_sel_t i_x_rd_a,
  input  reg_sel_t i_x_rd_b,
  output logic     o_issue_a,
  output logic     o_issue_b,
  output stall_t   o_bubble_a,
  output stall_t   o_bubble_b
);

  logic load_use_a;
  logic load_use_b;
  logic b_dep_a;     // b needs a's result or writes the same register
  logic mem_both;

  function automatic logic reads(ctrl_t ctrl, reg_sel_t rs, reg_sel_t rt, reg_sel_t sel);
    return (ctrl[CTRL_RS_RE] && rs == sel) || (ctrl[CTRL_RT_RE] && rt == sel);
  endfunction

  assign load_use_a = (i_x_load_a && reads(i_ctrl_a, i_rs_a, i_rt_a, i_x_rd_a)) ||
                      (i_x_load_b && reads(i_ctrl_a, i_rs_a, i_rt_a, i_x_rd_b));
  assign load_use_b = (i_x_load_a && reads(i_ctrl_b, i_rs_b, i_rt_b, i_x_rd_a)) ||
                      (i_x_load_b && reads(i_ctrl_b, i_rs_b, i_rt_b, i_x_rd_b));
  assign b_dep_a    = i_ctrl_a[CTRL_RF_WE] &&
                      (reads(i_ctrl_b, i_rs_b, i_rt_b, i_rd_a) ||
                       (i_ctrl_b[CTRL_RF_WE] && i_rd_b == i_rd_a));
  assign mem_both   = (i_ctrl_a[CTRL_IS_LOAD] || i_ctrl_a[CTRL_IS_STORE]) &&
                      (i_ctrl_b[CTRL_IS_LOAD] || i_ctrl_b[CTRL_IS_STORE]);

  always_comb begin
    o_issue_a  = 1'b0;
    o_issue_b  = 1'b0;
    o_bubble_a = STALL_RESET;
    o_bubble_b = STALL_RESET;
    if (!i_d_valid_a) begin
      // nothing fetched yet
    end else if (load_use_a) begin
      o_bubble_a = STALL_LOAD_USE;
      o_bubble_b = STALL_SUPERSCALAR;
    end else begin
      o_issue_a  = 1'b1;
      o_bubble_a = STALL_NONE;
      if (!i_d_valid_b)
        o_bubble_b = STALL_RESET;
      else if (load_use_b)
        o_bubble_b = STALL_LOAD_USE;
      else if (b_dep_a || mem_both)  // single memory port
        o_bubble_b = STALL_SUPERSCALAR;
      else begin
        o_issue_b  = 1'b1;
        o_bubble_b = STALL_NONE;
      end
    end
  end

endmodule

/* source/lc4ss_lane.sv */
`timescale 1ns/1ps

module lc4ss_lane import lc4ss_pkg::*; (
  input  logic     gwe,
  input  logic     i_reset,
  input  logic     i_issue,
  input  stall_t   i_bubble,
  input  word_t    i_insn,
  input  word_t    i_pc,
  input  ctrl_t    i_ctrl,
  input  reg_sel_t i_rs,
  input  reg_sel_t i_rt,
  input  reg_sel_t i_rd,
  input  word_t    i_rs_data,
  input  word_t    i_rt_data,
  input  logic     i_m_we_a,
  input  logic     i_m_we_b,
  input  reg_sel_t i_m_rd_a,
  input  reg_sel_t i_m_rd_b,
  input  word_t    i_m_data_a,
  input  word_t    i_m_data_b,
  input  logic     i_w_we_a,
  input  logic     i_w_we_b,
  input  reg_sel_t i_w_rd_a,
  input  reg_sel_t i_w_rd_b,
  input  word_t    i_w_data_a,
  input  word_t    i_w_data_b,
  output logic     o_x_load,
  output reg_sel_t o_x_rd,
  output logic     o_m_we,
  output reg_sel_t o_m_rd,
  output word_t    o_m_data,
  output word_t    o_dmem_addr,
  output word_t    o_dmem_wdata,
  output logic     o_dmem_we,
  input  word_t    i_dmem_rdata,
  output stall_t   o_wb_stall,
  output word_t    o_wb_pc,
  output word_t    o_wb_insn,
  output logic     o_wb_rf_we,
  output reg_sel_t o_wb_wsel,
  output word_t    o_wb_wdata
);

  stall_t   x_stall, m_stall;
  ctrl_t    x_ctrl, m_ctrl;
  word_t    x_insn, x_pc, x_rs_data, x_rt_data;
  reg_sel_t x_rs, x_rt, x_rd, m_rd;
  word_t    x_rs_op, x_rt_op, x_result;
  word_t    m_insn, m_pc, m_result, m_st_data;
  logic     m_load, m_store;

  // youngest producer first as m.b then m.a then w.b then w.a
  function automatic word_t bypass(reg_sel_t sel, word_t rf_data);
    if (i_m_we_b && i_m_rd_b == sel)
      return i_m_data_b;
    if (i_m_we_a && i_m_rd_a == sel)
      return i_m_data_a;
    if (i_w_we_b && i_w_rd_b == sel)
      return i_w_data_b;
    if (i_w_we_a && i_w_rd_a == sel)
      return i_w_data_a;
    return rf_data;
  endfunction

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      x_stall <= STALL_RESET;
      x_ctrl  <= '0;
      m_stall <= STALL_RESET;
      m_ctrl  <= '0;
    end else begin
      x_stall <= i_issue ? STALL_NONE : i_bubble;
      x_ctrl  <= i_issue ? i_ctrl : '0;  // a bubble does nothing
      m_stall <= x_stall;
      m_ctrl  <= x_ctrl;
    end
  end

  always_ff @(posedge gwe) begin
    x_insn    <= i_insn;
    x_pc      <= i_pc;
    x_rs      <= i_rs;
    x_rt      <= i_rt;
    x_rd      <= i_rd;
    x_rs_data <= i_rs_data;
    x_rt_data <= i_rt_data;
    m_insn    <= x_insn;
    m_pc      <= x_pc;
    m_rd      <= x_rd;
    m_result  <= x_result;
    m_st_data <= x_rt_op;
  end

  assign x_rs_op = bypass(x_rs, x_rs_data);
  assign x_rt_op = bypass(x_rt, x_rt_data);

  lc4ss_alu u_alu (
    .i_insn    (x_insn),
    .i_rs_data (x_rs_op),
    .i_rt_data (x_rt_op),
    .o_result  (x_result)
  );

  assign o_x_load = x_ctrl[CTRL_IS_LOAD];
  assign o_x_rd   = x_rd;

  assign m_load   = m_ctrl[CTRL_IS_LOAD];
  assign m_store  = m_ctrl[CTRL_IS_STORE];
  // load data reaches the bypass only from w
  assign o_m_we   = m_ctrl[CTRL_RF_WE] && !m_load;
  assign o_m_rd   = m_rd;
  assign o_m_data = m_load ? i_dmem_rdata : m_result;

  // zeros when idle so the core can or both lanes
  assign o_dmem_addr  = (m_load || m_store) ? m_result : '0;
  assign o_dmem_we    = m_store;
  assign o_dmem_wdata = m_store ? m_st_data : '0;

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      o_wb_stall <= STALL_RESET;
      o_wb_rf_we <= 1'b0;
    end else begin
      o_wb_stall <= m_stall;
      o_wb_rf_we <= m_ctrl[CTRL_RF_WE];
    end
  end

  always_ff @(posedge gwe) begin
    o_wb_pc    <= m_pc;
    o_wb_insn  <= m_insn;
    o_wb_wsel  <= m_rd;
    o_wb_wdata <= o_m_data;
  end

endmodule

/* source/lc4ss_core.sv */
`timescale 1ns/1ps

module lc4ss_core import lc4ss_pkg::*; (
  input  logic     gwe,
  input  logic     i_reset,
  output word_t    o_imem_pc,
  input  word_t    i_imem_insn_a,
  input  word_t    i_imem_insn_b,
  output word_t    o_dmem_addr,
  output logic     o_dmem_we,
  output word_t    o_dmem_wdata,
  input  word_t    i_dmem_rdata,
  output stall_t   o_wb_stall_a,
  output word_t    o_wb_pc_a,
  output word_t    o_wb_insn_a,
  output logic     o_wb_rf_we_a,
  output reg_sel_t o_wb_wsel_a,
  output word_t    o_wb_wdata_a,
  output stall_t   o_wb_stall_b,
  output word_t    o_wb_pc_b,
  output word_t    o_wb_insn_b,
  output logic     o_wb_rf_we_b,
  output reg_sel_t o_wb_wsel_b,
  output word_t    o_wb_wdata_b
);

  logic     d_valid_a, d_valid_b;
  word_t    d_insn_a, d_insn_b, d_pc_a, d_pc_b;
  ctrl_t    ctrl_a, ctrl_b;
  reg_sel_t rs_a, rt_a, rd_a, rs_b, rt_b, rd_b;
  word_t    rs_data_a, rt_data_a, rs_data_b, rt_data_b;
  logic     issue_a, issue_b;
  stall_t   bubble_a, bubble_b;
  logic     x_load_a, x_load_b;
  reg_sel_t x_rd_a, x_rd_b;
  logic     m_we_a, m_we_b;
  reg_sel_t m_rd_a, m_rd_b;
  word_t    m_data_a, m_data_b;
  word_t    dmem_addr_a, dmem_addr_b, dmem_wdata_a, dmem_wdata_b;
  logic     dmem_we_a, dmem_we_b;

  lc4ss_fetch u_fetch (
    .gwe, .i_reset, .i_issue_a(issue_a), .i_issue_b(issue_b),
    .i_imem_insn_a, .i_imem_insn_b, .o_imem_pc,
    .o_d_valid_a(d_valid_a), .o_d_valid_b(d_valid_b),
    .o_d_insn_a(d_insn_a), .o_d_insn_b(d_insn_b),
    .o_d_pc_a(d_pc_a), .o_d_pc_b(d_pc_b)
  );

  lc4ss_decoder u_dec_a (
    .i_insn(d_insn_a), .o_ctrl(ctrl_a), .o_rs(rs_a), .o_rt(rt_a), .o_rd(rd_a)
  );

  lc4ss_decoder u_dec_b (
    .i_insn(d_insn_b), .o_ctrl(ctrl_b), .o_rs(rs_b), .o_rt(rt_b), .o_rd(rd_b)
  );

  lc4ss_issue u_issue (
    .i_d_valid_a(d_valid_a), .i_d_valid_b(d_valid_b),
    .i_ctrl_a(ctrl_a), .i_ctrl_b(ctrl_b),
    .i_rs_a(rs_a), .i_rt_a(rt_a), .i_rd_a(rd_a),
    .i_rs_b(rs_b), .i_rt_b(rt_b), .i_rd_b(rd_b),
    .i_x_load_a(x_load_a), .i_x_load_b(x_load_b),
    .i_x_rd_a(x_rd_a), .i_x_rd_b(x_rd_b),
    .o_issue_a(issue_a), .o_issue_b(issue_b),
    .o_bubble_a(bubble_a), .o_bubble_b(bubble_b)
  );

  // read in decode, written from both w stages
  lc4ss_regfile u_regfile (
    .gwe, .i_reset,
    .i_rs_a(rs_a), .i_rt_a(rt_a), .i_rs_b(rs_b), .i_rt_b(rt_b),
    .o_rs_data_a(rs_data_a), .o_rt_data_a(rt_data_a),
    .o_rs_data_b(rs_data_b), .o_rt_data_b(rt_data_b),
    .i_we_a(o_wb_rf_we_a), .i_we_b(o_wb_rf_we_b),
    .i_wsel_a(o_wb_wsel_a), .i_wsel_b(o_wb_wsel_b),
    .i_wdata_a(o_wb_wdata_a), .i_wdata_b(o_wb_wdata_b)
  );

  lc4ss_lane u_lane_a (
    .gwe, .i_reset, .i_issue(issue_a), .i_bubble(bubble_a),
    .i_insn(d_insn_a), .i_pc(d_pc_a), .i_ctrl(ctrl_a),
    .i_rs(rs_a), .i_rt(rt_a), .i_rd(rd_a),
    .i_rs_data(rs_data_a), .i_rt_data(rt_data_a),
    .i_m_we_a(m_we_a), .i_m_we_b(m_we_b), .i_m_rd_a(m_rd_a), .i_m_rd_b(m_rd_b),
    .i_m_data_a(m_data_a), .i_m_data_b(m_data_b),
    .i_w_we_a(o_wb_rf_we_a), .i_w_we_b(o_wb_rf_we_b),
    .i_w_rd_a(o_wb_wsel_a), .i_w_rd_b(o_wb_wsel_b),
    .i_w_data_a(o_wb_wdata_a), .i_w_data_b(o_wb_wdata_b),
    .o_x_load(x_load_a), .o_x_rd(x_rd_a),
    .o_m_we(m_we_a), .o_m_rd(m_rd_a), .o_m_data(m_data_a),
    .o_dmem_addr(dmem_addr_a), .o_dmem_wdata(dmem_wdata_a),
    .o_dmem_we(dmem_we_a), .i_dmem_rdata,
    .o_wb_stall(o_wb_stall_a), .o_wb_pc(o_wb_pc_a), .o_wb_insn(o_wb_insn_a),
    .o_wb_rf_we(o_wb_rf_we_a), .o_wb_wsel(o_wb_wsel_a), .o_wb_wdata(o_wb_wdata_a)
  );

  lc4ss_lane u_lane_b (
    .gwe, .i_reset, .i_issue(issue_b), .i_bubble(bubble_b),
    .i_insn(d_insn_b), .i_pc(d_pc_b), .i_ctrl(ctrl_b),
    .i_rs(rs_b), .i_rt(rt_b), .i_rd(rd_b),
    .i_rs_data(rs_data_b), .i_rt_data(rt_data_b),
    .i_m_we_a(m_we_a), .i_m_we_b(m_we_b), .i_m_rd_a(m_rd_a), .i_m_rd_b(m_rd_b),
    .i_m_data_a(m_data_a), .i_m_data_b(m_data_b),
    .i_w_we_a(o_wb_rf_we_a), .i_w_we_b(o_wb_rf_we_b),
    .i_w_rd_a(o_wb_wsel_a), .i_w_rd_b(o_wb_wsel_b),
    .i_w_data_a(o_wb_wdata_a), .i_w_data_b(o_wb_wdata_b),
    .o_x_load(x_load_b), .o_x_rd(x_rd_b),
    .o_m_we(m_we_b), .o_m_rd(m_rd_b), .o_m_data(m_data_b),
    .o_dmem_addr(dmem_addr_b), .o_dmem_wdata(dmem_wdata_b),
    .o_dmem_we(dmem_we_b), .i_dmem_rdata,
    .o_wb_stall(o_wb_stall_b), .o_wb_pc(o_wb_pc_b), .o_wb_insn(o_wb_insn_b),
    .o_wb_rf_we(o_wb_rf_we_b), .o_wb_wsel(o_wb_wsel_b), .o_wb_wdata(o_wb_wdata_b)
  );

  // issue keeps at most one lane on the port, the idle one drives zeros
  assign o_dmem_addr  = dmem_addr_a | dmem_addr_b;
  assign o_dmem_we    = dmem_we_a | dmem_we_b;
  assign o_dmem_wdata = dmem_wdata_a | dmem_wdata_b;

endmodule

/* sim/lc4ss_sva.sv */
`timescale 1ns/1ps

module lc4ss_sva import lc4ss_pkg::*; (
  input logic   gwe,
  input logic   i_reset,
  input word_t  i_imem_pc,
  input word_t  i_dmem_addr,
  input logic   i_dmem_we,
  input logic   i_x_load_a,
  input logic   i_x_load_b,
  input stall_t i_wb_stall_a,
  input logic   i_wb_rf_we_a,
  input word_t  i_wb_pc_a,
  input stall_t i_wb_stall_b,
  input logic   i_wb_rf_we_b,
  input word_t  i_wb_pc_b
);

  // a bubble never writes the register file
  bubble_no_write_a: assert property (@(posedge gwe) disable iff (i_reset)
    (i_wb_stall_a != STALL_NONE) |-> !i_wb_rf_we_a)
    else $error("lane a bubble has rf_we set");
  bubble_no_write_b: assert property (@(posedge gwe) disable iff (i_reset)
    (i_wb_stall_b != STALL_NONE) |-> !i_wb_rf_we_b)
    else $error("lane b bubble has rf_we set");

  pair_in_order: assert property (@(posedge gwe) disable iff (i_reset)
    (i_wb_stall_a == STALL_NONE && i_wb_stall_b == STALL_NONE) |->
      (i_wb_pc_b == word_t'(i_wb_pc_a + 16'd1)))
    else $error("lane b pc is not lane a pc plus one");

  pc_step: assert property (@(posedge gwe) disable iff (i_reset)
    word_t'(i_imem_pc - $past(i_imem_pc)) <= 16'd2)
    else $error("fetch pc moved by more than two");

  // x load flag one cycle ago means a load sits in m now
  dmem_idle_zero: assert property (@(posedge gwe) disable iff (i_reset)
    (!i_dmem_we && !$past(i_x_load_a || i_x_load_b)) |-> (i_dmem_addr == 16'd0))
    else $error("data address not zero while the port is idle");

endmodule

bind lc4ss_core lc4ss_sva u_sva (
  .gwe          (gwe),
  .i_reset      (i_reset),
  .i_imem_pc    (o_imem_pc),
  .i_dmem_addr  (o_dmem_addr),
  .i_dmem_we    (o_dmem_we),
  .i_x_load_a   (x_load_a),
  .i_x_load_b   (x_load_b),
  .i_wb_stall_a (o_wb_stall_a),
  .i_wb_rf_we_a (o_wb_rf_we_a),
  .i_wb_pc_a    (o_wb_pc_a),
  .i_wb_stall_b (o_wb_stall_b),
  .i_wb_rf_we_b (o_wb_rf_we_b),
  .i_wb_pc_b    (o_wb_pc_b)
);

/* sim/lc4ss_tb.sv */
`timescale 1ns/1ps

module lc4ss_tb import lc4ss_pkg::*; ();

  logic     gwe;
  logic     i_reset;
  word_t    o_imem_pc, pc_next;
  word_t    i_imem_insn_a, i_imem_insn_b;
  word_t    o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
  logic     o_dmem_we;
  stall_t   o_wb_stall_a, o_wb_stall_b;
  word_t    o_wb_pc_a, o_wb_insn_a, o_wb_wdata_a;
  word_t    o_wb_pc_b, o_wb_insn_b, o_wb_wdata_b;
  logic     o_wb_rf_we_a, o_wb_rf_we_b;
  reg_sel_t o_wb_wsel_a, o_wb_wsel_b;

  word_t       imem [0:65535] = '{default: '0};  // 16'h0000 is a nop
  word_t       dmem [0:65535] = '{default: '0};
  logic [43:0] recs [0:63] = '{default: '0};     // kind, word, we, wsel, data
  int          n_prog, errors, retired, n_super, n_load_use;
  word_t       end_pc;

  lc4ss_core i_dut (.*);

  always #10 gwe = ~gwe;

  assign pc_next       = o_imem_pc + 16'd1;
  assign i_imem_insn_a = imem[o_imem_pc];
  assign i_imem_insn_b = imem[pc_next];
  assign i_dmem_rdata  = dmem[o_dmem_addr];  // combinational read

  always @(posedge gwe) begin
    if (o_dmem_we)
      dmem[o_dmem_addr] <= o_dmem_wdata;
  end

  task automatic compare_word(input string name, input word_t exp, input word_t got);
    assert (got == exp) else begin
      $display("ERR %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  // checks one trace slot against the next program line in order
  task automatic check_slot(input string lane, input stall_t stall, input word_t pc,
                            input word_t insn, input logic rf_we, input reg_sel_t wsel,
                            input word_t wdata);
    logic [43:0] rec;
    if (stall == STALL_SUPERSCALAR && lane == "b")
      n_super++;
    if (stall == STALL_LOAD_USE)
      n_load_use++;
    if (stall == STALL_NONE && retired < n_prog) begin
      rec = recs[retired];
      compare_word({"o_wb_pc_", lane}, RESET_PC + 16'(retired), pc);
      compare_word({"o_wb_insn_", lane}, rec[39:24], insn);
      compare_word({"o_wb_rf_we_", lane}, 16'(rec[20]), 16'(rf_we));
      if (rec[20]) begin  // select and data only mean something on a write
        compare_word({"o_wb_wsel_", lane}, 16'(rec[18:16]), 16'(wsel));
        compare_word({"o_wb_wdata_", lane}, rec[15:0], wdata);
      end
      retired++;
    end else if (stall == STALL_NONE) begin
      assert (pc >= end_pc) else begin
        $display("lane %s retired pc %h more than once", lane, pc);
        errors++;
      end
    end
  endtask

  initial begin
    int cycles;
    gwe        = 1'b0;
    i_reset    = 1'b1;
    n_prog     = 0;
    errors     = 0;
    retired    = 0;
    n_super    = 0;
    n_load_use = 0;

    $readmemh("sim/lc4ss_input.txt", recs);
    for (int i = 0; i < 64; i++) begin
      if (recs[i][43:40] == 4'd1) begin
        imem[RESET_PC + 16'(n_prog)] = recs[i][39:24];
        n_prog++;
      end
    end
    end_pc = RESET_PC + 16'(n_prog);

    repeat (2) @(posedge gwe);
    @(negedge gwe);
    i_reset = 1'b0;

    // pipeline still holds reset bubbles
    @(negedge gwe);
    compare_word("o_wb_stall_a", 16'(STALL_RESET), 16'(o_wb_stall_a));
    compare_word("o_wb_stall_b", 16'(STALL_RESET), 16'(o_wb_stall_b));
    compare_word("o_wb_rf_we_a", 16'd0, 16'(o_wb_rf_we_a));
    compare_word("o_wb_rf_we_b", 16'd0, 16'(o_wb_rf_we_b));
    compare_word("o_dmem_we", 16'd0, 16'(o_dmem_we));

    cycles = 0;
    while (retired < n_prog && cycles < 200) begin
      @(negedge gwe);
      check_slot("a", o_wb_stall_a, o_wb_pc_a, o_wb_insn_a, o_wb_rf_we_a,
                 o_wb_wsel_a, o_wb_wdata_a);
      check_slot("b", o_wb_stall_b, o_wb_pc_b, o_wb_insn_b, o_wb_rf_we_b,
                 o_wb_wsel_b, o_wb_wdata_b);
      cycles++;
    end
    assert (retired == n_prog) else begin
      $display("timeout after %0d cycles, only %0d of %0d instructions retired",
               cycles, retired, n_prog);
      errors++;
    end

    repeat (6) begin  // drain so stores finish and late duplicates show up
      @(negedge gwe);
      check_slot("a", o_wb_stall_a, o_wb_pc_a, o_wb_insn_a, o_wb_rf_we_a,
                 o_wb_wsel_a, o_wb_wdata_a);
      check_slot("b", o_wb_stall_b, o_wb_pc_b, o_wb_insn_b, o_wb_rf_we_b,
                 o_wb_wsel_b, o_wb_wdata_b);
    end

    for (int i = 0; i < 64; i++) begin
      if (recs[i][43:40] == 4'd2)
        compare_word($sformatf("dmem[%h]", recs[i][39:24]), recs[i][15:0],
                     dmem[recs[i][39:24]]);
    end

    assert (n_super > 0) else begin
      $display("no lane b trace slot showed a superscalar stall");
      errors++;
    end
    assert (n_load_use > 0) else begin
      $display("no trace slot showed a load-use stall");
      errors++;
    end

    $display("errors: %0d  retired: %0d  superscalar stalls: %0d  load-use stalls: %0d",
             errors, retired, n_super, n_load_use);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* lc4ss.f */
source/lc4ss_pkg.sv
source/lc4ss_decoder.sv
source/lc4ss_alu.sv
source/lc4ss_regfile.sv
source/lc4ss_fetch.sv
source/lc4ss_issue.sv
source/lc4ss_lane.sv
source/lc4ss_core.sv
sim/lc4ss_sva.sv
sim/lc4ss_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module lc4ss_tb \
  -f lc4ss.f -o lc4ss_sim \
  && ./obj_dir/lc4ss_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -qx "TEST PASSED" sim.log || exit 1
exit 0

/* sim/lc4ss_input.txt */
// kind_word_we_wsel_data, kind 1 is a program line: insn, expected rf_we, wsel, wdata
// kind 2 is a memory line: address in the word field, expected final word in data
1_9205_1_1_0005  // const r1, #5
1_9403_1_2_0003  // const r2, #3
1_1642_1_3_0008  // add r3, r1, r2
1_1852_1_4_0002  // sub r4, r1, r2
1_5AC4_1_5_0000  // and r5, r3, r4
1_5CD4_1_6_000A  // or r6, r3, r4
1_5E5B_1_7_000D  // xor r7, r1, r3
1_1FC1_1_7_0012  // add r7, r7, r1  needs lane a result
1_127F_1_1_0004  // add r1, r1, #-1
1_9410_1_2_0010  // const r2, #16
1_7C80_0_0_0000  // str r6, r2, #0
1_7E81_0_0_0000  // str r7, r2, #1  second memory op
1_6680_1_3_000A  // ldr r3, r2, #0
1_18C1_1_4_000E  // add r4, r3, r1  load-use
1_6A81_1_5_0012  // ldr r5, r2, #1
1_1B62_1_5_0014  // add r5, r5, #2
1_9DFE_1_6_FFFE  // const r6, #-2
1_7C82_0_0_0000  // str r6, r2, #2
1_6082_1_0_FFFE  // ldr r0, r2, #2
1_521D_1_1_FFEA  // xor r1, r0, r5
1_0000_0_0_0000  // nop
1_1441_1_2_FFD4  // add r2, r1, r1
2_0010_0_0_000A
2_0011_0_0_0012
2_0012_0_0_FFFE
2_0013_0_0_0000  // never written
